// File: project.f
+incdir+source
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_decode.sv
source/cpu_operands.sv
source/cpu_frontend.sv
testbench/cpu_frontend_assertions.sv
testbench/cpu_frontend_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = cpu_frontend_tb
FILELIST  = project.f
OBJDIR    = obj_dir
PASS_TEXT = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@output="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// File: testbench/cpu_frontend_vectors.txt
# P index value : register preload through the write port
# I pc instr fault alu op1 op2 rs2_value imm rd have_rd mread mwrite width signed jump jcond
P 01 00000010
P 02 fffffff0
P 03 12345678
P 04 00000004
P 00 deadbeef
I 00000100 123452b7 0 0 00000000 12345000 12345678 12345000 05 1 0 0 0 0 0 0
I 00001000 fffff317 0 0 00001000 fffff000 00000000 fffff000 06 1 0 0 0 0 0 0
I 00002000 ff9ff0ef 0 0 00002000 fffffff8 00000000 fffffff8 01 1 0 0 0 0 1 0
I 00002004 00408067 0 0 00000010 00000004 00000004 00000004 00 0 0 0 0 0 1 0
I 00003000 fe2088e3 0 1 00000010 fffffff0 fffffff0 fffffff0 11 0 0 0 0 0 0 1
I 00003004 0041e463 0 4 12345678 00000004 00000004 00000008 08 0 0 0 0 0 0 1
I 00004000 ffc12383 0 0 fffffff0 fffffffc 00000000 fffffffc 07 1 1 0 2 1 0 0
I 00004004 0030c403 0 0 00000010 00000003 12345678 00000003 08 1 1 0 0 0 0 0
I 00004008 fe30a623 0 0 00000010 ffffffec 12345678 ffffffec 0c 0 0 1 2 0 0 0
I 0000400c 00219323 0 0 12345678 00000006 fffffff0 00000006 06 0 0 1 1 0 0 0
I 00005000 002084b3 0 0 00000010 fffffff0 fffffff0 00000000 09 1 0 0 0 0 0 0
I 00005004 40018533 0 1 12345678 00000000 00000000 00000000 0a 1 0 0 0 0 0 0
I 00005008 404155b3 0 7 fffffff0 00000004 00000004 00000000 0b 1 0 0 0 0 0 0
I 0000500c 00303633 0 4 00000000 12345678 12345678 00000000 0c 1 0 0 0 0 0 0
I 00005010 fff1c693 0 5 12345678 ffffffff 00000000 ffffffff 0d 1 0 0 0 0 0 0
I 00005014 40315713 0 7 fffffff0 00000403 12345678 00000403 0e 1 0 0 0 0 0 0
I 00005018 0f00f013 0 9 00000010 000000f0 00000000 000000f0 00 0 0 0 0 0 0 0
I 00006000 0020808b 1 0 00000000 fffffff0 fffffff0 00000000 01 0 0 0 0 0 0 0
I 00006004 02208133 1 0 00000000 fffffff0 fffffff0 00000000 02 0 0 0 0 0 0 0
I 00006008 002084b1 1 0 00000000 fffffff0 fffffff0 00000000 09 0 0 0 0 0 0 0
I 0000600c 40209133 1 0 00000000 fffffff0 fffffff0 00000000 02 0 0 0 0 0 0 0

// File: testbench/cpu_frontend_tb.sv
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_frontend_tb;

	import cpu_pkg::*;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
		logic [31:0] fault;
		logic [31:0] alu;
		logic [31:0] operand1;
		logic [31:0] operand2;
		logic [31:0] rs2_value;
		logic [31:0] imm;
		logic [31:0] rd;
		logic [31:0] have_rd;
		logic [31:0] memory_read;
		logic [31:0] memory_write;
		logic [31:0] memory_width;
		logic [31:0] memory_signed;
		logic [31:0] jump;
		logic [31:0] jump_conditional;
	} vector_t;

	logic                            clock;
	logic                            reset;
	logic                            strobe;
	logic [`CPU_XLEN-1:0]            pc;
	logic [31:0]                     instruction;
	logic                            write_strobe;
	logic [`CPU_REG_INDEX_WIDTH-1:0] write_index;
	logic [`CPU_XLEN-1:0]            write_value;
	logic                            o_strobe;
	logic                            o_fault;
	logic [`CPU_XLEN-1:0]            o_pc;
	alu_operation_e                  o_alu_operation;
	logic [`CPU_XLEN-1:0]            o_operand1;
	logic [`CPU_XLEN-1:0]            o_operand2;
	logic [`CPU_XLEN-1:0]            o_rs2_value;
	logic [`CPU_XLEN-1:0]            o_imm;
	logic [`CPU_REG_INDEX_WIDTH-1:0] o_rd;
	logic                            o_have_rd;
	logic                            o_memory_read;
	logic                            o_memory_write;
	memory_width_e                   o_memory_width;
	logic                            o_memory_signed;
	logic                            o_jump;
	logic                            o_jump_conditional;

	vector_t     vectors[$];
	logic [4:0]  preload_index[$];
	logic [31:0] preload_value[$];
	int          pending_vector[$];
	int          pending_edge[$];
	int          edge_count;
	int          check_errors;
	int          other_errors;

	cpu_frontend cpu_frontend_i (
		.i_clock            (clock),
		.i_reset            (reset),
		.i_strobe           (strobe),
		.i_pc               (pc),
		.i_instruction      (instruction),
		.i_write_strobe     (write_strobe),
		.i_write_index      (write_index),
		.i_write_value      (write_value),
		.o_strobe           (o_strobe),
		.o_fault            (o_fault),
		.o_pc               (o_pc),
		.o_alu_operation    (o_alu_operation),
		.o_operand1         (o_operand1),
		.o_operand2         (o_operand2),
		.o_rs2_value        (o_rs2_value),
		.o_imm              (o_imm),
		.o_rd               (o_rd),
		.o_have_rd          (o_have_rd),
		.o_memory_read      (o_memory_read),
		.o_memory_write     (o_memory_write),
		.o_memory_width     (o_memory_width),
		.o_memory_signed    (o_memory_signed),
		.o_jump             (o_jump),
		.o_jump_conditional (o_jump_conditional)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		edge_count <= edge_count + 1;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	// before any instruction the outputs must sit at their reset values.
	task automatic check_idle();
		check_value("o_strobe", o_strobe, 0);
		check_value("o_fault", o_fault, 0);
		check_value("o_have_rd", o_have_rd, 0);
		check_value("o_memory_read", o_memory_read, 0);
		check_value("o_memory_write", o_memory_write, 0);
		check_value("o_memory_signed", o_memory_signed, 0);
		check_value("o_jump", o_jump, 0);
		check_value("o_jump_conditional", o_jump_conditional, 0);
	endtask

	task automatic load_vectors();
		int      fd;
		int      count;
		string   line;
		logic [31:0] f[16];
		vector_t v;
		fd = $fopen("testbench/cpu_frontend_vectors.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the vector file");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0) begin
				continue;
			end
			if (line.getc(0) == "P") begin
				count = $sscanf(line, "P %h %h", f[0], f[1]);
				if (count == 2) begin
					preload_index.push_back(f[0][4:0]);
					preload_value.push_back(f[1]);
				end else begin
					other_errors++;
					$display("malformed preload line in the vector file");
				end
			end else if (line.getc(0) == "I") begin
				count = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
				if (count == 16) begin
					v = {f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
						f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]};
					vectors.push_back(v);
				end else begin
					other_errors++;
					$display("malformed instruction line in the vector file");
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic send_instructions(input int max_gap);
		int gap;
		foreach (vectors[i]) begin
			gap = (max_gap > 0) ? ($urandom % (max_gap + 1)) : 0;
			repeat (gap) begin
				@(negedge clock);
				strobe = 1'b0;
			end
			@(negedge clock);
			strobe      = 1'b1;
			pc          = vectors[i].pc;
			instruction = vectors[i].instruction;
			pending_vector.push_back(i);
			pending_edge.push_back(edge_count + 1);
		end
		@(negedge clock);
		strobe = 1'b0;
	endtask

	// outputs change on the rising edge, so the falling edge sees them settled.
	// the value seen here is the one the next rising edge samples.
	always @(negedge clock) begin
		int      n;
		vector_t e;
		if (!reset && o_strobe) begin
			if (pending_vector.size() == 0) begin
				other_errors++;
				$display("o_strobe at %0t with no instruction outstanding", $time);
			end else begin
				n = pending_vector.pop_front();
				e = vectors[n];
				check_value("latency", edge_count + 1, pending_edge.pop_front() + 3);
				check_value("o_pc", o_pc, e.pc);
				check_value("o_fault", o_fault, e.fault);
				check_value("o_alu_operation", o_alu_operation, e.alu);
				check_value("o_operand1", o_operand1, e.operand1);
				check_value("o_operand2", o_operand2, e.operand2);
				check_value("o_rs2_value", o_rs2_value, e.rs2_value);
				check_value("o_imm", o_imm, e.imm);
				check_value("o_rd", o_rd, e.rd);
				check_value("o_have_rd", o_have_rd, e.have_rd);
				check_value("o_memory_read", o_memory_read, e.memory_read);
				check_value("o_memory_write", o_memory_write, e.memory_write);
				check_value("o_memory_width", o_memory_width, e.memory_width);
				check_value("o_memory_signed", o_memory_signed, e.memory_signed);
				check_value("o_jump", o_jump, e.jump);
				check_value("o_jump_conditional", o_jump_conditional, e.jump_conditional);
			end
		end
	end

	initial begin
		int waited;
		int assertion_errors;
		clock        = 1'b0;
		reset        = 1'b1;
		strobe       = 1'b0;
		pc           = '0;
		instruction  = '0;
		write_strobe = 1'b0;
		write_index  = '0;
		write_value  = '0;
		edge_count   = 0;
		check_errors = 0;
		other_errors = 0;
		void'($urandom(32'hc8928224));
		load_vectors();
		if (vectors.size() == 0) begin
			other_errors++;
			$display("no instruction vectors were loaded");
		end
		repeat (8) @(negedge clock);
		reset = 1'b0;

		foreach (preload_index[i]) begin
			@(negedge clock);
			check_idle();
			write_strobe = 1'b1;
			write_index  = preload_index[i];
			write_value  = preload_value[i];
		end
		@(negedge clock);
		check_idle();
		write_strobe = 1'b0;
		repeat (3) begin
			@(negedge clock);
			check_idle();
		end

		send_instructions(0);
		send_instructions(3);

		waited = 0;
		while (pending_vector.size() != 0 && waited < 100) begin
			@(negedge clock);
			waited++;
		end
		if (pending_vector.size() != 0) begin
			other_errors++;
			$display("timeout with %0d results still missing", pending_vector.size());
		end
		repeat (2) @(negedge clock);

		assertion_errors = cpu_frontend_i.cpu_frontend_assertions_i.failures;
		$display("value errors: %0d, other errors: %0d, assertion errors: %0d",
			check_errors, other_errors, assertion_errors);
		if (check_errors == 0 && other_errors == 0 && assertion_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: testbench/cpu_frontend_assertions.sv
`timescale 1ns/100ps

module cpu_frontend_assertions (
	input logic i_clock,
	input logic i_reset,
	input logic i_strobe,
	input logic o_strobe,
	input logic o_fault,
	input logic o_memory_read,
	input logic o_memory_write
);

	// number of assertion failures, read by the testbench at the end of the run.
	int failures = 0;

	// a fault is only meaningful on a live output record.
	fault_with_strobe: assert property (@(posedge i_clock) disable iff (i_reset)
		o_fault |-> o_strobe)
		else begin
			$error("o_fault high without o_strobe");
			failures++;
		end

	read_write_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_memory_read && o_memory_write))
		else begin
			$error("o_memory_read and o_memory_write both high");
			failures++;
		end

	// the strobe captured at edge N leaves the last stage at edge N+2 and is sampled at N+3.
	fixed_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		o_strobe == $past(i_strobe, 3))
		else begin
			$error("o_strobe does not follow i_strobe by three cycles");
			failures++;
		end

endmodule

bind cpu_frontend cpu_frontend_assertions cpu_frontend_assertions_i (
	.i_clock        (i_clock),
	.i_reset        (i_reset),
	.i_strobe       (i_strobe),
	.o_strobe       (o_strobe),
	.o_fault        (o_fault),
	.o_memory_read  (o_memory_read),
	.o_memory_write (o_memory_write)
);

// File: source/cpu_frontend.sv
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_frontend (
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  logic                            i_strobe,
	input  logic [`CPU_XLEN-1:0]            i_pc,
	input  logic [31:0]                     i_instruction,
	input  logic                            i_write_strobe,
	input  logic [`CPU_REG_INDEX_WIDTH-1:0] i_write_index,
	input  logic [`CPU_XLEN-1:0]            i_write_value,
	output logic                            o_strobe,
	output logic                            o_fault,
	output logic [`CPU_XLEN-1:0]            o_pc,
	output cpu_pkg::alu_operation_e         o_alu_operation,
	output logic [`CPU_XLEN-1:0]            o_operand1,
	output logic [`CPU_XLEN-1:0]            o_operand2,
	output logic [`CPU_XLEN-1:0]            o_rs2_value,
	output logic [`CPU_XLEN-1:0]            o_imm,
	output logic [`CPU_REG_INDEX_WIDTH-1:0] o_rd,
	output logic                            o_have_rd,
	output logic                            o_memory_read,
	output logic                            o_memory_write,
	output cpu_pkg::memory_width_e          o_memory_width,
	output logic                            o_memory_signed,
	output logic                            o_jump,
	output logic                            o_jump_conditional
);

	import cpu_pkg::*;

	fetch_data_t  fetch_data;
	decode_data_t decode_data;

	cpu_fetch cpu_fetch_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_strobe      (i_strobe),
		.i_pc          (i_pc),
		.i_instruction (i_instruction),
		.o_data        (fetch_data)
	);

	cpu_decode cpu_decode_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_data  (fetch_data),
		.o_data  (decode_data)
	);

	cpu_operands cpu_operands_i (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_data             (decode_data),
		.i_write_strobe     (i_write_strobe),
		.i_write_index      (i_write_index),
		.i_write_value      (i_write_value),
		.o_strobe           (o_strobe),
		.o_fault            (o_fault),
		.o_pc               (o_pc),
		.o_alu_operation    (o_alu_operation),
		.o_operand1         (o_operand1),
		.o_operand2         (o_operand2),
		.o_rs2_value        (o_rs2_value),
		.o_imm              (o_imm),
		.o_rd               (o_rd),
		.o_have_rd          (o_have_rd),
		.o_memory_read      (o_memory_read),
		.o_memory_write     (o_memory_write),
		.o_memory_width     (o_memory_width),
		.o_memory_signed    (o_memory_signed),
		.o_jump             (o_jump),
		.o_jump_conditional (o_jump_conditional)
	);

endmodule

// File: source/cpu_operands.sv
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_operands (
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  cpu_pkg::decode_data_t           i_data,
	input  logic                            i_write_strobe,
	input  logic [`CPU_REG_INDEX_WIDTH-1:0] i_write_index,
	input  logic [`CPU_XLEN-1:0]            i_write_value,
	output logic                            o_strobe,
	output logic                            o_fault,
	output logic [`CPU_XLEN-1:0]            o_pc,
	output cpu_pkg::alu_operation_e         o_alu_operation,
	output logic [`CPU_XLEN-1:0]            o_operand1,
	output logic [`CPU_XLEN-1:0]            o_operand2,
	output logic [`CPU_XLEN-1:0]            o_rs2_value,
	output logic [`CPU_XLEN-1:0]            o_imm,
	output logic [`CPU_REG_INDEX_WIDTH-1:0] o_rd,
	output logic                            o_have_rd,
	output logic                            o_memory_read,
	output logic                            o_memory_write,
	output cpu_pkg::memory_width_e          o_memory_width,
	output logic                            o_memory_signed,
	output logic                            o_jump,
	output logic                            o_jump_conditional
);

	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0] registers [`CPU_REG_COUNT];
	logic [`CPU_XLEN-1:0] rs1_value;
	logic [`CPU_XLEN-1:0] rs2_value;
	logic [`CPU_XLEN-1:0] operand1_value;
	logic [`CPU_XLEN-1:0] operand2_value;

	// x0 is never written, so it keeps the zero it got at reset.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				registers[i] <= '0;
			end
		end else if (i_write_strobe && (i_write_index != '0)) begin
			registers[i_write_index] <= i_write_value;
		end
	end

	// the read happens a cycle after decode, so a write at that edge is already in place.
	assign rs1_value = registers[i_data.inst_rs1];
	assign rs2_value = registers[i_data.inst_rs2];

	always_comb begin
		case (i_data.alu_operand1)
			operand1_rs1: operand1_value = rs1_value;
			operand1_pc: operand1_value = i_data.pc;
			default: operand1_value = '0;
		endcase
	end

	assign operand2_value = (i_data.alu_operand2 == operand2_imm) ? i_data.imm : rs2_value;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_strobe           <= 1'b0;
			o_fault            <= 1'b0;
			o_pc               <= '0;
			o_alu_operation    <= alu_add;
			o_operand1         <= '0;
			o_operand2         <= '0;
			o_rs2_value        <= '0;
			o_imm              <= '0;
			o_rd               <= '0;
			o_have_rd          <= 1'b0;
			o_memory_read      <= 1'b0;
			o_memory_write     <= 1'b0;
			o_memory_width     <= memory_byte;
			o_memory_signed    <= 1'b0;
			o_jump             <= 1'b0;
			o_jump_conditional <= 1'b0;
		end else begin
			o_strobe           <= i_data.strobe;
			o_fault            <= i_data.fault;
			o_pc               <= i_data.pc;
			o_alu_operation    <= i_data.alu_operation;
			o_operand1         <= operand1_value;
			o_operand2         <= operand2_value;
			o_rs2_value        <= rs2_value;
			o_imm              <= i_data.imm;
			o_rd               <= i_data.inst_rd;
			o_have_rd          <= i_data.have_rd;
			o_memory_read      <= i_data.memory_read;
			o_memory_write     <= i_data.memory_write;
			o_memory_width     <= i_data.memory_width;
			o_memory_signed    <= i_data.memory_signed;
			o_jump             <= i_data.jump;
			o_jump_conditional <= i_data.jump_conditional;
		end
	end

endmodule

// File: source/cpu_decode.sv
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_decode (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  cpu_pkg::fetch_data_t  i_data,
	output cpu_pkg::decode_data_t o_data
);

	import cpu_pkg::*;

	// major opcodes, bits 6:2 of the instruction.
	localparam logic [4:0] opcode_load   = 5'b00000;
	localparam logic [4:0] opcode_op_imm = 5'b00100;
	localparam logic [4:0] opcode_auipc  = 5'b00101;
	localparam logic [4:0] opcode_store  = 5'b01000;
	localparam logic [4:0] opcode_op     = 5'b01100;
	localparam logic [4:0] opcode_lui    = 5'b01101;
	localparam logic [4:0] opcode_branch = 5'b11000;
	localparam logic [4:0] opcode_jalr   = 5'b11001;
	localparam logic [4:0] opcode_jal    = 5'b11011;

	logic [31:0] inst;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;

	logic is_u;
	logic is_j;
	logic is_i;
	logic is_b;
	logic is_s;
	logic is_r;

	logic [`CPU_XLEN-1:0] imm_i;
	logic [`CPU_XLEN-1:0] imm_s;
	logic [`CPU_XLEN-1:0] imm_b;
	logic [`CPU_XLEN-1:0] imm_u;
	logic [`CPU_XLEN-1:0] imm_j;
	logic [`CPU_XLEN-1:0] imm;

	logic             illegal;
	logic             have_rd;
	alu_operation_e   alu_operation;
	operand1_select_e operand1;
	operand2_select_e operand2;
	logic             memory_read;
	logic             memory_write;
	memory_width_e    memory_width;
	logic             memory_signed;
	logic             jump;
	logic             jump_conditional;

	decode_data_t data;

	// funct3 picks the operation, alternate selects sub and sra.
	function automatic alu_operation_e alu_from_funct3(input logic [2:0] funct,
		input logic alternate);
		alu_operation_e operation;
		case (funct)
			3'b000: operation = alternate ? alu_sub : alu_add;
			3'b001: operation = alu_sll;
			3'b010: operation = alu_slt;
			3'b011: operation = alu_sltu;
			3'b100: operation = alu_xor;
			3'b101: operation = alternate ? alu_sra : alu_srl;
			3'b110: operation = alu_or;
			default: operation = alu_and;
		endcase
		return operation;
	endfunction

	assign inst   = i_data.instruction;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{21{inst[31]}}, inst[30:20]};
	assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		is_u = 1'b0;
		is_j = 1'b0;
		is_i = 1'b0;
		is_b = 1'b0;
		is_s = 1'b0;
		is_r = 1'b0;
		case (opcode[6:2])
			opcode_lui, opcode_auipc: is_u = 1'b1;
			opcode_jal: is_j = 1'b1;
			opcode_jalr, opcode_load, opcode_op_imm: is_i = 1'b1;
			opcode_branch: is_b = 1'b1;
			opcode_store: is_s = 1'b1;
			opcode_op: is_r = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		// every RV32I word ends in binary 11, anything else is compressed or invalid.
		illegal          = (opcode[1:0] != 2'b11);
		alu_operation    = alu_add;
		operand1         = operand1_zero;
		operand2         = operand2_rs2;
		memory_read      = 1'b0;
		memory_write     = 1'b0;
		memory_width     = memory_byte;
		memory_signed    = 1'b0;
		jump             = 1'b0;
		jump_conditional = 1'b0;
		case (opcode[6:2])
			opcode_lui: begin
				operand2 = operand2_imm;
			end
			opcode_auipc: begin
				operand1 = operand1_pc;
				operand2 = operand2_imm;
			end
			opcode_jal: begin
				operand1 = operand1_pc;
				operand2 = operand2_imm;
				jump     = 1'b1;
			end
			opcode_jalr: begin
				illegal  = illegal | (funct3 != 3'b000);
				operand1 = operand1_rs1;
				operand2 = operand2_imm;
				jump     = 1'b1;
			end
			opcode_branch: begin
				operand1         = operand1_rs1;
				jump_conditional = 1'b1;
				case (funct3[2:1])
					2'b00: alu_operation = alu_sub;
					2'b10: alu_operation = alu_slt;
					2'b11: alu_operation = alu_sltu;
					default: illegal = 1'b1;
				endcase
			end
			opcode_load: begin
				// lb, lh, lw, lbu and lhu are the only loads.
				illegal       = illegal | (funct3[1] & (funct3[0] | funct3[2]));
				operand1      = operand1_rs1;
				operand2      = operand2_imm;
				memory_read   = 1'b1;
				memory_width  = memory_width_e'(funct3[1:0]);
				memory_signed = ~funct3[2];
			end
			opcode_store: begin
				illegal      = illegal | funct3[2] | (funct3[1] & funct3[0]);
				operand1     = operand1_rs1;
				operand2     = operand2_imm;
				memory_write = 1'b1;
				memory_width = memory_width_e'(funct3[1:0]);
			end
			opcode_op_imm: begin
				operand1      = operand1_rs1;
				operand2      = operand2_imm;
				alu_operation = alu_from_funct3(funct3, funct7[5] & (funct3 == 3'b101));
				// the upper immediate bits of a shift are really funct7.
				if (funct3 == 3'b001) begin
					illegal = illegal | (funct7 != 7'b0000000);
				end else if (funct3 == 3'b101) begin
					illegal = illegal | ((funct7 & 7'b1011111) != 7'b0000000);
				end
			end
			opcode_op: begin
				operand1      = operand1_rs1;
				alu_operation = alu_from_funct3(funct3, funct7[5]);
				if (funct7 == 7'b0100000) begin
					illegal = illegal | ((funct3 != 3'b000) & (funct3 != 3'b101));
				end else begin
					illegal = illegal | (funct7 != 7'b0000000);
				end
			end
			default: illegal = 1'b1;
		endcase

		// a faulting instruction leaves as a harmless add of zero.
		if (illegal) begin
			alu_operation    = alu_add;
			operand1         = operand1_zero;
			operand2         = operand2_rs2;
			memory_read      = 1'b0;
			memory_write     = 1'b0;
			memory_width     = memory_byte;
			memory_signed    = 1'b0;
			jump             = 1'b0;
			jump_conditional = 1'b0;
		end
	end

	assign imm = illegal ? '0 :
		is_u ? imm_u :
		is_j ? imm_j :
		is_i ? imm_i :
		is_b ? imm_b :
		is_s ? imm_s :
		'0;

	assign have_rd = (is_u | is_j | is_i | is_r) & (i_data.inst_rd != '0) & ~illegal;

	assign o_data = data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			data <= '0;
		end else begin
			data.strobe   <= i_data.strobe;
			data.fault    <= i_data.strobe & illegal;
			data.pc       <= i_data.pc;
			data.inst_rs1 <= i_data.inst_rs1;
			data.inst_rs2 <= i_data.inst_rs2;
			data.inst_rd  <= i_data.inst_rd;
			data.imm      <= imm;

			data.alu_operation <= alu_operation;
			data.alu_operand1  <= operand1;
			data.alu_operand2  <= operand2;

			// controls only go high for a live record.
			data.have_rd          <= i_data.strobe & have_rd;
			data.memory_read      <= i_data.strobe & memory_read;
			data.memory_write     <= i_data.strobe & memory_write;
			data.memory_width     <= memory_width;
			data.memory_signed    <= i_data.strobe & memory_signed;
			data.jump             <= i_data.strobe & jump;
			data.jump_conditional <= i_data.strobe & jump_conditional;
		end
	end

endmodule

// File: source/cpu_fetch.sv
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_fetch (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_strobe,
	input  logic [`CPU_XLEN-1:0] i_pc,
	input  logic [31:0]          i_instruction,
	output cpu_pkg::fetch_data_t o_data
);

	import cpu_pkg::*;

	// register fields sit at the same bits in every format that has them.
	logic [`CPU_REG_INDEX_WIDTH-1:0] field_rs1;
	logic [`CPU_REG_INDEX_WIDTH-1:0] field_rs2;
	logic [`CPU_REG_INDEX_WIDTH-1:0] field_rd;

	fetch_data_t data;

	assign field_rs1 = i_instruction[19:15];
	assign field_rs2 = i_instruction[24:20];
	assign field_rd  = i_instruction[11:7];

	assign o_data = data;

	// the payload follows the inputs on every edge.
	// only the strobe tells the next stage whether the record is live.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			data <= '0;
		end else begin
			data.strobe      <= i_strobe;
			data.pc          <= i_pc;
			data.instruction <= i_instruction;
			data.inst_rs1    <= field_rs1;
			data.inst_rs2    <= field_rs2;
			data.inst_rd     <= field_rd;
		end
	end

endmodule

// File: source/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	// the values the execute stage understands.
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_operation_e;

	// zero is the encoding a cleared or faulting record falls back to.
	typedef enum logic [1:0] {
		operand1_zero = 2'd0,
		operand1_rs1  = 2'd1,
		operand1_pc   = 2'd2
	} operand1_select_e;

	typedef enum logic {
		operand2_rs2 = 1'b0,
		operand2_imm = 1'b1
	} operand2_select_e;

	// encoded as funct3[1:0] of the load and store instructions.
	typedef enum logic [1:0] {
		memory_byte = 2'd0,
		memory_half = 2'd1,
		memory_word = 2'd2
	} memory_width_e;

	typedef struct packed {
		logic                            strobe;
		logic [`CPU_XLEN-1:0]            pc;
		logic [31:0]                     instruction;
		logic [`CPU_REG_INDEX_WIDTH-1:0] inst_rs1;
		logic [`CPU_REG_INDEX_WIDTH-1:0] inst_rs2;
		logic [`CPU_REG_INDEX_WIDTH-1:0] inst_rd;
	} fetch_data_t;

	typedef struct packed {
		logic                            strobe;
		logic                            fault;
		logic [`CPU_XLEN-1:0]            pc;
		logic [`CPU_REG_INDEX_WIDTH-1:0] inst_rs1;
		logic [`CPU_REG_INDEX_WIDTH-1:0] inst_rs2;
		logic [`CPU_REG_INDEX_WIDTH-1:0] inst_rd;
		logic                            have_rd;
		logic [`CPU_XLEN-1:0]            imm;
		alu_operation_e                  alu_operation;
		operand1_select_e                alu_operand1;
		operand2_select_e                alu_operand2;
		logic                            memory_read;
		logic                            memory_write;
		memory_width_e                   memory_width;
		logic                            memory_signed;
		logic                            jump;
		logic                            jump_conditional;
	} decode_data_t;

endpackage

// File: source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width, fixed at 32 by RV32I.
`define CPU_XLEN 32

// number of integer registers, x0 included.
`define CPU_REG_COUNT 32

// bits needed to name one integer register.
`define CPU_REG_INDEX_WIDTH 5

`endif
